// File: Bender.yml
package:
  name: sd_host

sources:
  - verilog/sd_cmd_pkg.sv
  - verilog/sd_dat_pkg.sv
  - verilog/sd_crc7.sv
  - verilog/sd_crc16.sv
  - verilog/sd_cmd_tx.sv
  - verilog/sd_resp_rx.sv
  - verilog/sd_dat_rx.sv
  - verilog/sd_host_top.sv
  - target: test
    files:
      - testbench/sd_card_model.sv
      - testbench/tb_sd_host.sv

// File: compile.f
verilog/sd_cmd_pkg.sv
verilog/sd_dat_pkg.sv
verilog/sd_crc7.sv
verilog/sd_crc16.sv
verilog/sd_cmd_tx.sv
verilog/sd_resp_rx.sv
verilog/sd_dat_rx.sv
verilog/sd_host_top.sv
testbench/sd_card_model.sv
testbench/tb_sd_host.sv

// File: testbench/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model
    import sd_cmd_pkg::*, sd_dat_pkg::*;
(
    input  logic                 clk_int,
    output logic                 cmd_to_host,
    output logic [DAT_LINES-1:0] dat_to_host
);

    // Bus idles high on CMD and on every DAT line
    initial begin
        cmd_to_host = 1'b1;
        dat_to_host = '1;
    end

    // ==================================================
    // CRC arithmetic, bit-serial from the generators
    // ==================================================

    // x^7 + x^3 + 1 over the content bits, MSB first
    function automatic logic [CRC7_BITS-1:0] crc7_of(input logic [CMD_CONTENT_BITS-1:0] bits);
        logic [CRC7_BITS-1:0] crc;
        logic                 fb;
        crc = '0;
        for (int i = CMD_CONTENT_BITS - 1; i >= 0; i--) begin
            fb  = bits[i] ^ crc[CRC7_BITS-1];
            crc = {crc[CRC7_BITS-2:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    // x^16 + x^12 + x^5 + 1 over one line of the block
    function automatic logic [CRC16_BITS-1:0] crc16_of_line(
        input logic [BLOCK_NIBBLES*DAT_LINES-1:0] block,
        input int                                 line
    );
        logic [CRC16_BITS-1:0] crc;
        logic                  fb;
        crc = '0;
        for (int k = 0; k < BLOCK_NIBBLES; k++) begin
            fb  = block[DAT_LINES*k + line] ^ crc[CRC16_BITS-1];
            crc = {crc[CRC16_BITS-2:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return crc;
    endfunction

    function automatic logic [CMD_FRAME_BITS-1:0] make_frame(
        input logic [CMD_CONTENT_BITS-1:0] content
    );
        return {content, crc7_of(content), 1'b1};
    endfunction

    // ==================================================
    // Bus activity
    // ==================================================

    // Gap in clocks, then the frame MSB first
    task automatic send_response(input logic [CMD_FRAME_BITS-1:0] frame, input int gap);
        repeat (gap) @(posedge clk_int);
        for (int i = CMD_FRAME_BITS - 1; i >= 0; i--) begin
            cmd_to_host <= frame[i];
            @(posedge clk_int);
        end
        cmd_to_host <= 1'b1;
    endtask

    // Start nibble, data, CRC per line, end nibble; bad_line below 0 keeps all CRCs good
    task automatic send_block(
        input logic [BLOCK_NIBBLES*DAT_LINES-1:0] block,
        input int                                 gap,
        input int                                 bad_line
    );
        logic [CRC16_BITS-1:0] crc [DAT_LINES];
        for (int l = 0; l < DAT_LINES; l++) begin
            crc[l] = crc16_of_line(block, l);
        end
        if (bad_line >= 0) begin
            crc[bad_line] = crc[bad_line] ^ 16'h0100;
        end
        repeat (gap) @(posedge clk_int);
        dat_to_host <= '0;
        @(posedge clk_int);
        for (int k = 0; k < BLOCK_NIBBLES; k++) begin
            dat_to_host <= block[DAT_LINES*k +: DAT_LINES];
            @(posedge clk_int);
        end
        for (int b = CRC16_BITS - 1; b >= 0; b--) begin
            dat_to_host <= {crc[3][b], crc[2][b], crc[1][b], crc[0][b]};
            @(posedge clk_int);
        end
        // End nibble, and the lines stay high after it
        dat_to_host <= '1;
    endtask

    task automatic set_dat(input logic [DAT_LINES-1:0] value);
        @(posedge clk_int);
        dat_to_host <= value;
    endtask

endmodule

// File: testbench/tb_sd_host.sv
`timescale 1ns/1ps

module tb_sd_host
    import sd_cmd_pkg::*, sd_dat_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 400;

    logic                      clk_int = 1'b0;
    logic                      init_rstPulse;
    logic                      cmd_trigger;
    cmd_req_t                  cmd_req;
    logic                      cmd_in;
    logic [DAT_LINES-1:0]      dat_in;
    logic                      cmd_out;
    logic                      cmd_oe;
    logic                      cmd_done;
    logic                      resp_done;
    resp_t                     resp;
    logic                      dat_done;
    dat_result_t               dat_result;
    logic                      status_dat0_idle;

    logic [CMD_FRAME_BITS-1:0] tx_frame = '0;
    int                        oe_cycles = 0;
    int                        cmd_done_cnt = 0;
    int                        resp_done_cnt = 0;
    int                        dat_done_cnt = 0;
    int                        errors = 0;
    int                        tests_run = 0;
    logic [31:0]               rng = 32'd15;

    always #20 clk_int = ~clk_int;

    sd_host_top uut (
        .clk_int          (clk_int),
        .init_rstPulse    (init_rstPulse),
        .cmd_trigger      (cmd_trigger),
        .cmd_req          (cmd_req),
        .cmd_in           (cmd_in),
        .dat_in           (dat_in),
        .cmd_out          (cmd_out),
        .cmd_oe           (cmd_oe),
        .cmd_done         (cmd_done),
        .resp_done        (resp_done),
        .resp             (resp),
        .dat_done         (dat_done),
        .dat_result       (dat_result),
        .status_dat0_idle (status_dat0_idle)
    );

    sd_card_model card (
        .clk_int     (clk_int),
        .cmd_to_host (cmd_in),
        .dat_to_host (dat_in)
    );

    // Bus monitor, sampled mid-cycle
    always @(negedge clk_int) begin
        if (cmd_oe) begin
            tx_frame  <= {tx_frame[CMD_FRAME_BITS-2:0], cmd_out};
            oe_cycles <= oe_cycles + 1;
        end
        if (cmd_done) cmd_done_cnt <= cmd_done_cnt + 1;
        if (resp_done) resp_done_cnt <= resp_done_cnt + 1;
        if (dat_done) dat_done_cnt <= dat_done_cnt + 1;
    end

    // ==================================================
    // Helpers
    // ==================================================
    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic [BLOCK_NIBBLES*DAT_LINES-1:0] random_block();
        logic [BLOCK_NIBBLES*DAT_LINES-1:0] blk;
        for (int w = 0; w < BLOCK_NIBBLES * DAT_LINES / 32; w++) begin
            blk[32*w +: 32] = next_rand();
        end
        return blk;
    endfunction

    function automatic logic [CMD_CONTENT_BITS-1:0] cmd_content(input logic [5:0] idx,
                                                                input logic [31:0] arg);
        return {2'b01, idx, arg};
    endfunction

    // 0 cmd_done, 1 resp_done, 2 dat_done
    function automatic int pulse_count(input int sel);
        case (sel)
            0: return cmd_done_cnt;
            1: return resp_done_cnt;
            default: return dat_done_cnt;
        endcase
    endfunction

    task automatic report_mismatch(input string test, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("ERROR %s: expected %0h, actual %0h", test, expected, actual);
        errors++;
    endtask

    task automatic wait_pulse(input int sel, input int base, input string what);
        int cycles;
        cycles = 0;
        while (pulse_count(sel) == base && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk_int);
            cycles++;
        end
        if (pulse_count(sel) == base) begin
            $display("Timeout: no %s pulse within %0d cycles", what, TIMEOUT_CYCLES);
            errors++;
        end
    endtask

    task automatic wait_dat0(input logic level);
        int cycles;
        cycles = 0;
        while (status_dat0_idle !== level && cycles < 8) begin
            @(negedge clk_int);
            cycles++;
        end
        if (status_dat0_idle !== level) begin
            $display("Timeout: status_dat0_idle never went to %0b", level);
            errors++;
        end
    endtask

    task automatic send_cmd(input logic [CMD_CONTENT_BITS-1:0] content, input logic resp_exp,
                            input logic dat_exp);
        int base;
        base = cmd_done_cnt;
        @(posedge clk_int);
        cmd_req     <= {content, resp_exp, dat_exp};
        cmd_trigger <= 1'b1;
        @(posedge clk_int);
        cmd_trigger <= 1'b0;
        wait_pulse(0, base, "cmd_done");
    endtask

    // ==================================================
    // Directed tests
    // ==================================================
    task automatic test_cmd0();
        int oe_base;
        int done_base;
        tests_run++;
        oe_base   = oe_cycles;
        done_base = cmd_done_cnt;
        send_cmd(cmd_content(6'd0, 32'd0), 1'b0, 1'b0);
        repeat (4) @(negedge clk_int);
        if (tx_frame !== 48'h400000000095) begin
            report_mismatch("cmd0_frame", 48'h400000000095, tx_frame);
        end
        if (oe_cycles - oe_base != 48) begin
            report_mismatch("cmd0_oe_cycles", 48, oe_cycles - oe_base);
        end
        if (cmd_done_cnt - done_base != 1) begin
            report_mismatch("cmd0_done", 1, cmd_done_cnt - done_base);
        end
    endtask

    // Flip 0 gives a clean response, else that frame bit is inverted
    task automatic test_response(input string name, input int flip);
        logic [CMD_FRAME_BITS-1:0] frame;
        int                        base;
        tests_run++;
        frame = card.make_frame({2'b00, 6'd13, next_rand()});
        if (flip > 0) frame = frame ^ (48'd1 << flip);
        base = resp_done_cnt;
        send_cmd(cmd_content(6'd13, next_rand()), 1'b1, 1'b0);
        card.send_response(frame, 4 + next_rand() % 8);
        wait_pulse(1, base, "resp_done");
        if (resp.frame !== frame) report_mismatch(name, frame, resp.frame);
        if (resp.crc_err !== (flip > 0)) report_mismatch(name, flip > 0, resp.crc_err);
    endtask

    task automatic test_block(input string name, input int bad_line);
        logic [BLOCK_NIBBLES*DAT_LINES-1:0] block;
        int                                 base;
        tests_run++;
        block = random_block();
        base  = dat_done_cnt;
        send_cmd(cmd_content(6'd6, 32'h80FFFFF1), 1'b0, 1'b1);
        card.send_block(block, 2 + next_rand() % 8, bad_line);
        wait_pulse(2, base, "dat_done");
        if (dat_result.crc_err !== (bad_line >= 0)) begin
            report_mismatch(name, bad_line >= 0, dat_result.crc_err);
        end
        if (bad_line < 0 && dat_result.access_mode !== block[4*ACCESS_MODE_NIBBLE +: 4]) begin
            report_mismatch(name, block[4*ACCESS_MODE_NIBBLE +: 4], dat_result.access_mode);
        end
    endtask

    task automatic test_dat0_idle();
        tests_run++;
        card.set_dat(4'hE);
        wait_dat0(1'b0);
        card.set_dat(4'hF);
        wait_dat0(1'b1);
    endtask

    // Unanswered command, then a new trigger aborts the pending receive
    task automatic test_abort();
        logic [CMD_FRAME_BITS-1:0] frame;
        int                        base;
        tests_run++;
        frame = card.make_frame({2'b00, 6'd9, next_rand()});
        base  = resp_done_cnt;
        send_cmd(cmd_content(6'd9, 32'h0001_0000), 1'b1, 1'b0);
        repeat (20) @(posedge clk_int);
        send_cmd(cmd_content(6'd9, 32'h0001_0000), 1'b1, 1'b0);
        card.send_response(frame, 4 + next_rand() % 8);
        wait_pulse(1, base, "resp_done");
        repeat (10) @(negedge clk_int);
        if (resp_done_cnt - base != 1) report_mismatch("abort_done", 1, resp_done_cnt - base);
        if (resp.frame !== frame) report_mismatch("abort_frame", frame, resp.frame);
        if (resp.crc_err !== 1'b0) report_mismatch("abort_crc", 0, resp.crc_err);
    endtask

    initial begin
        init_rstPulse = 1'b1;
        cmd_trigger   = 1'b0;
        cmd_req       = '0;
        repeat (5) @(posedge clk_int);
        init_rstPulse <= 1'b0;
        repeat (2) @(posedge clk_int);
        test_cmd0();
        test_response("resp_ok", 0);
        test_response("resp_bad_crc", 1 + next_rand() % 7);
        test_block("block_ok", -1);
        test_block("block_bad_crc", next_rand() % 4);
        test_dat0_idle();
        test_abort();
        $display("Tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: verilog/sd_cmd_pkg.sv
package sd_cmd_pkg;

    // ==================================================
    // Command and response frame geometry
    // ==================================================
    localparam int unsigned CMD_FRAME_BITS    = 48;
    localparam int unsigned CMD_CONTENT_BITS  = 40;
    localparam int unsigned CRC7_BITS         = 7;
    // Cycles after driver release where CMD is still settling
    localparam int unsigned TURNAROUND_CYCLES = 3;
    localparam int unsigned BIT_CNT_W         = $clog2(CMD_FRAME_BITS);

    // Start bit, direction, index, argument
    typedef struct packed {
        logic        start_bit;
        logic        dir_bit;
        logic [5:0]  index;
        logic [31:0] arg;
    } cmd_content_t;

    typedef struct packed {
        cmd_content_t content;
        logic         resp_expected;
        logic         dat_expected;
    } cmd_req_t;

    typedef struct packed {
        logic [CMD_FRAME_BITS-1:0] frame;
        logic                      crc_err;
    } resp_t;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_SEND,
        CMD_CRC,
        CMD_STOP
    } cmd_state_e;

    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_WAIT_START,
        RESP_SHIFT,
        RESP_CHECK
    } resp_state_e;

endpackage

// File: verilog/sd_cmd_tx.sv
`timescale 1ns/1ps

module sd_cmd_tx
    import sd_cmd_pkg::*;
(
    input  logic     clk_int,
    input  logic     init_rstPulse,
    input  logic     cmd_trigger,
    input  cmd_req_t cmd_req,
    output logic     cmd_out,
    output logic     cmd_oe,
    output logic     cmd_done,
    output logic     resp_start,
    output logic     dat_start,
    output logic     abort
);

    cmd_state_e                  state_q;
    logic [BIT_CNT_W-1:0]        bit_cnt_q;
    logic [CMD_CONTENT_BITS-1:0] shift_q;
    logic [CRC7_BITS-1:0]        crc;
    logic                        crc_en;

    assign crc_en = (state_q == CMD_SEND);

    sd_crc7 u_crc7 (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .clear         (cmd_trigger),
        .enable        (crc_en),
        .data_bit      (shift_q[CMD_CONTENT_BITS-1]),
        .crc           (crc)
    );

    // Content MSB first, then CRC, then the end bit; idle line is high
    always_comb begin
        case (state_q)
            CMD_SEND: cmd_out = shift_q[CMD_CONTENT_BITS-1];
            CMD_CRC:  cmd_out = crc[CRC7_BITS-1-bit_cnt_q];
            default:  cmd_out = 1'b1;
        endcase
    end

    always_ff @(posedge clk_int) begin
        if (cmd_trigger) begin
            shift_q <= cmd_req.content;
        end else if (state_q == CMD_SEND) begin
            shift_q <= {shift_q[CMD_CONTENT_BITS-2:0], 1'b0};
        end
    end

    // ==================================================
    // Frame FSM
    // ==================================================
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            state_q    <= CMD_IDLE;
            bit_cnt_q  <= '0;
            cmd_oe     <= 1'b0;
            cmd_done   <= 1'b0;
            resp_start <= 1'b0;
            dat_start  <= 1'b0;
            abort      <= 1'b0;
        end else begin
            cmd_done   <= 1'b0;
            resp_start <= 1'b0;
            dat_start  <= 1'b0;
            abort      <= cmd_trigger;
            bit_cnt_q  <= bit_cnt_q + 1'b1;
            if (cmd_trigger) begin
                // New trigger always restarts the frame
                state_q   <= CMD_SEND;
                bit_cnt_q <= '0;
                cmd_oe    <= 1'b1;
            end else begin
                case (state_q)
                    CMD_SEND: begin
                        if (bit_cnt_q == BIT_CNT_W'(CMD_CONTENT_BITS - 1)) begin
                            state_q   <= CMD_CRC;
                            bit_cnt_q <= '0;
                        end
                    end
                    CMD_CRC: begin
                        if (bit_cnt_q == BIT_CNT_W'(CRC7_BITS - 1)) begin
                            state_q <= CMD_STOP;
                        end
                    end
                    CMD_STOP: begin
                        state_q    <= CMD_IDLE;
                        cmd_oe     <= 1'b0;
                        cmd_done   <= 1'b1;
                        resp_start <= cmd_req.resp_expected;
                        dat_start  <= cmd_req.dat_expected;
                    end
                    default: begin
                        bit_cnt_q <= '0;
                    end
                endcase
            end
        end
    end

    // Request must not move while its frame is on the line
    a_req_stable: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        cmd_oe && !cmd_trigger |-> $stable(cmd_req));

endmodule

// File: verilog/sd_crc16.sv
`timescale 1ns/1ps

module sd_crc16 (
    input  logic        clk_int,
    input  logic        init_rstPulse,
    input  logic        clear,
    input  logic        enable,
    input  logic        data_bit,
    output logic [15:0] crc
);

    logic feedback;

    // CCITT generator x^16 + x^12 + x^5 + 1
    assign feedback = data_bit ^ crc[15];

    always_ff @(posedge clk_int) begin
        if (init_rstPulse || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[14:12], crc[11] ^ feedback, crc[10:5], crc[4] ^ feedback,
                    crc[3:0], feedback};
        end
    end

endmodule

// File: verilog/sd_crc7.sv
`timescale 1ns/1ps

module sd_crc7 (
    input  logic       clk_int,
    input  logic       init_rstPulse,
    input  logic       clear,
    input  logic       enable,
    input  logic       data_bit,
    output logic [6:0] crc
);

    logic feedback;

    // Generator x^7 + x^3 + 1
    assign feedback = data_bit ^ crc[6];

    always_ff @(posedge clk_int) begin
        if (init_rstPulse || clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[5:3], crc[2] ^ feedback, crc[1:0], feedback};
        end
    end

endmodule

// File: verilog/sd_dat_pkg.sv
package sd_dat_pkg;

    // ==================================================
    // Read block geometry
    // ==================================================
    localparam int unsigned DAT_LINES          = 4;
    localparam int unsigned BLOCK_NIBBLES      = 128;
    localparam int unsigned CRC16_BITS         = 16;
    // CMD6 status nibble holding the group 1 result
    localparam int unsigned ACCESS_MODE_NIBBLE = 33;
    localparam int unsigned NIBBLE_CNT_W       = $clog2(BLOCK_NIBBLES);

    typedef struct packed {
        logic       crc_err;
        logic [3:0] access_mode;
    } dat_result_t;

    typedef enum logic [2:0] {
        DAT_IDLE,
        DAT_WAIT_START,
        DAT_DATA,
        DAT_CRC,
        DAT_END
    } dat_state_e;

endpackage

// File: verilog/sd_dat_rx.sv
`timescale 1ns/1ps

module sd_dat_rx
    import sd_dat_pkg::*;
(
    input  logic                 clk_int,
    input  logic                 init_rstPulse,
    input  logic [DAT_LINES-1:0] dat_in,
    input  logic                 dat_start,
    input  logic                 abort,
    output logic                 dat_done,
    output dat_result_t          dat_result,
    output logic                 status_dat0_idle
);

    dat_state_e              state_q;
    logic [DAT_LINES-1:0]    dat_q;
    logic [NIBBLE_CNT_W-1:0] cnt_q;
    logic                    crc_en;
    logic [CRC16_BITS-1:0]   crc_calc [DAT_LINES];
    logic [CRC16_BITS-1:0]   crc_rx_q [DAT_LINES];
    logic [DAT_LINES-1:0]    line_ok;
    logic [3:0]              access_mode_q;
    logic                    crc_err_q;

    assign crc_en           = (state_q == DAT_DATA);
    assign status_dat0_idle = dat_q[0];
    assign dat_result       = '{crc_err: crc_err_q, access_mode: access_mode_q};

    // One CRC16 per DAT line
    for (genvar i = 0; i < DAT_LINES; i++) begin : g_line
        sd_crc16 u_crc16 (
            .clk_int       (clk_int),
            .init_rstPulse (init_rstPulse),
            .clear         (dat_start),
            .enable        (crc_en),
            .data_bit      (dat_q[i]),
            .crc           (crc_calc[i])
        );
        assign line_ok[i] = (crc_rx_q[i] == crc_calc[i]);
    end

    always_ff @(posedge clk_int) begin
        // Received CRC nibbles, MSB first on every line
        if (state_q == DAT_CRC && cnt_q < NIBBLE_CNT_W'(CRC16_BITS)) begin
            for (int i = 0; i < DAT_LINES; i++) begin
                crc_rx_q[i] <= {crc_rx_q[i][CRC16_BITS-2:0], dat_q[i]};
            end
        end
        if (state_q == DAT_DATA && cnt_q == NIBBLE_CNT_W'(ACCESS_MODE_NIBBLE)) begin
            access_mode_q <= dat_q;
        end
    end

    // ==================================================
    // Block FSM
    // ==================================================
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            state_q   <= DAT_IDLE;
            dat_q     <= '0;
            cnt_q     <= '0;
            dat_done  <= 1'b0;
            crc_err_q <= 1'b0;
        end else begin
            dat_q    <= dat_in;
            dat_done <= 1'b0;
            cnt_q    <= cnt_q + 1'b1;
            if (dat_start) begin
                state_q <= DAT_WAIT_START;
            end else if (abort) begin
                state_q <= DAT_IDLE;
            end else begin
                case (state_q)
                    DAT_WAIT_START: begin
                        cnt_q <= '0;
                        if (!dat_q[0]) begin
                            state_q <= DAT_DATA;
                        end
                    end
                    DAT_DATA: begin
                        if (cnt_q == NIBBLE_CNT_W'(BLOCK_NIBBLES - 1)) begin
                            cnt_q   <= '0;
                            state_q <= DAT_CRC;
                        end
                    end
                    DAT_CRC: begin
                        // Last count holds the end nibble
                        if (cnt_q == NIBBLE_CNT_W'(CRC16_BITS)) begin
                            crc_err_q <= !(&line_ok) || (dat_q != '1);
                            dat_done  <= 1'b1;
                            state_q   <= DAT_END;
                        end
                    end
                    DAT_END: begin
                        state_q <= DAT_IDLE;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // The command side never launches a block over a live one
    a_start_when_idle: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        dat_start |-> (state_q == DAT_IDLE || abort));

endmodule

// File: verilog/sd_host_top.sv
`timescale 1ns/1ps

module sd_host_top
    import sd_cmd_pkg::*, sd_dat_pkg::*;
(
    input  logic        clk_int,
    input  logic        init_rstPulse,
    input  logic        cmd_trigger,
    input  cmd_req_t    cmd_req,
    input  logic        cmd_in,
    input  logic [3:0]  dat_in,
    output logic        cmd_out,
    output logic        cmd_oe,
    output logic        cmd_done,
    output logic        resp_done,
    output resp_t       resp,
    output logic        dat_done,
    output dat_result_t dat_result,
    output logic        status_dat0_idle
);

    // Launch and abort strobes from the command side
    logic resp_start;
    logic dat_start;
    logic abort;

    sd_cmd_tx u_cmd_tx (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .cmd_trigger   (cmd_trigger),
        .cmd_req       (cmd_req),
        .cmd_out       (cmd_out),
        .cmd_oe        (cmd_oe),
        .cmd_done      (cmd_done),
        .resp_start    (resp_start),
        .dat_start     (dat_start),
        .abort         (abort)
    );

    sd_resp_rx u_resp_rx (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .cmd_in        (cmd_in),
        .cmd_oe        (cmd_oe),
        .resp_start    (resp_start),
        .abort         (abort),
        .resp_done     (resp_done),
        .resp          (resp)
    );

    sd_dat_rx u_dat_rx (
        .clk_int          (clk_int),
        .init_rstPulse    (init_rstPulse),
        .dat_in           (dat_in),
        .dat_start        (dat_start),
        .abort            (abort),
        .dat_done         (dat_done),
        .dat_result       (dat_result),
        .status_dat0_idle (status_dat0_idle)
    );

endmodule

// File: verilog/sd_resp_rx.sv
`timescale 1ns/1ps

module sd_resp_rx
    import sd_cmd_pkg::*;
(
    input  logic  clk_int,
    input  logic  init_rstPulse,
    input  logic  cmd_in,
    input  logic  cmd_oe,
    input  logic  resp_start,
    input  logic  abort,
    output logic  resp_done,
    output resp_t resp
);

    resp_state_e                  state_q;
    logic                         cmd_in_q;
    logic [TURNAROUND_CYCLES-1:0] oe_hist_q;
    logic                         rx_bit;
    logic [CMD_FRAME_BITS-1:0]    shift_q;
    logic [BIT_CNT_W-1:0]         bit_cnt_q;
    logic [CRC7_BITS-1:0]         crc;
    logic                         crc_en;
    logic [CMD_FRAME_BITS-1:0]    frame_q;
    logic                         crc_err_q;

    // Force the line high while driving and during turnaround
    assign rx_bit = (cmd_oe || (|oe_hist_q)) ? 1'b1 : cmd_in_q;

    // CRC covers the first 40 bits, start bit included
    assign crc_en = (state_q == RESP_WAIT_START && !rx_bit) ||
                    (state_q == RESP_SHIFT && bit_cnt_q < BIT_CNT_W'(CMD_CONTENT_BITS));

    assign resp = '{frame: frame_q, crc_err: crc_err_q};

    sd_crc7 u_crc7 (
        .clk_int       (clk_int),
        .init_rstPulse (init_rstPulse),
        .clear         (resp_start),
        .enable        (crc_en),
        .data_bit      (rx_bit),
        .crc           (crc)
    );

    always_ff @(posedge clk_int) begin
        if (state_q == RESP_WAIT_START || state_q == RESP_SHIFT) begin
            shift_q <= {shift_q[CMD_FRAME_BITS-2:0], rx_bit};
        end
        if (state_q == RESP_CHECK) begin
            frame_q <= shift_q;
        end
    end

    // ==================================================
    // Response FSM
    // ==================================================
    always_ff @(posedge clk_int) begin
        if (init_rstPulse) begin
            state_q   <= RESP_IDLE;
            cmd_in_q  <= 1'b1;
            oe_hist_q <= '0;
            bit_cnt_q <= '0;
            resp_done <= 1'b0;
            crc_err_q <= 1'b0;
        end else begin
            cmd_in_q  <= cmd_in;
            oe_hist_q <= {oe_hist_q[TURNAROUND_CYCLES-2:0], cmd_oe};
            resp_done <= 1'b0;
            if (resp_start) begin
                state_q <= RESP_WAIT_START;
            end else if (abort) begin
                state_q <= RESP_IDLE;
            end else begin
                case (state_q)
                    RESP_WAIT_START: begin
                        // Start bit counts as bit 0 of the frame
                        bit_cnt_q <= BIT_CNT_W'(1);
                        if (!rx_bit) begin
                            state_q <= RESP_SHIFT;
                        end
                    end
                    RESP_SHIFT: begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_CNT_W'(CMD_FRAME_BITS - 1)) begin
                            state_q <= RESP_CHECK;
                        end
                    end
                    RESP_CHECK: begin
                        crc_err_q <= (shift_q[CRC7_BITS:1] != crc) || !shift_q[0];
                        resp_done <= 1'b1;
                        state_q   <= RESP_IDLE;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // The command side never launches a response over a live one
    a_start_when_idle: assert property (@(posedge clk_int) disable iff (init_rstPulse)
        resp_start |-> (state_q == RESP_IDLE || abort));

endmodule
